/* hdl/sv32_pkg.sv */
package sv32_pkg;

    // Sv32 address widths
    localparam int VA_W       = 32;
    localparam int PA_W       = 34;
    localparam int PAGE_OFS_W = 12;
    localparam int VPN_W      = 20;
    localparam int PPN_W      = 22;

    // Width of one VPN level index, VPN[1] or VPN[0]
    localparam int VPN_PART_W = VPN_W / 2;

    // TLB geometry and page table entry size
    localparam int TLB_ENTRIES = 4;
    localparam int TLB_PTR_W   = $clog2(TLB_ENTRIES);
    localparam int PTE_BYTES   = 4;

    typedef logic [VA_W-1:0]  vaddr_t;
    typedef logic [PA_W-1:0]  paddr_t;
    typedef logic [VPN_W-1:0] vpn_t;
    typedef logic [PPN_W-1:0] ppn_t;

    // Page table entry as laid out in memory, v in bit 0
    typedef struct packed {
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    // One cached translation
    typedef struct packed {
        logic valid;
        vpn_t vpn;
        ppn_t ppn;
        logic page_4m;
    } tlb_entry_t;

endpackage

/* hdl/mmu_ctrl_pkg.sv */
package mmu_ctrl_pkg;

    // Page table walker FSM
    // L1 and L0 states hold a memory read until it is acknowledged
    typedef enum logic [2:0] {
        PTW_IDLE,
        PTW_L1_REQ,
        PTW_L0_REQ,
        PTW_FILL,
        PTW_ERROR
    } ptw_state_e;

    // Which side started the current walk
    typedef enum logic {
        WALK_INSTR,
        WALK_DATA
    } walk_src_e;

endpackage

/* hdl/tlb_lookup_if.sv */
`timescale 1ns/1ns

interface tlb_lookup_if;

    // Request side
    logic           req;
    sv32_pkg::vpn_t vpn;
    logic           flush;

    // Response side, combinational from the TLB entries
    logic           hit;
    sv32_pkg::ppn_t ppn;
    logic           page_4m;

    modport requester (
        output req,
        output vpn,
        output flush,
        input  hit,
        input  ppn,
        input  page_4m
    );

    modport tlb (
        input  req,
        input  vpn,
        input  flush,
        output hit,
        output ppn,
        output page_4m
    );

endinterface

/* hdl/tlb_fill_if.sv */
`timescale 1ns/1ns

interface tlb_fill_if;

    // One-cycle write strobes, one per TLB
    logic           update_i;
    logic           update_d;

    // New translation from the walker
    sv32_pkg::vpn_t vpn;
    sv32_pkg::pte_t pte;
    logic           page_4m;

    modport walker (
        output update_i,
        output update_d,
        output vpn,
        output pte,
        output page_4m
    );

    modport tlb (
        input update_i,
        input update_d,
        input vpn,
        input pte,
        input page_4m
    );

endinterface

/* hdl/tlb.sv */
`timescale 1ns/1ns

module tlb (
    input  logic      clk,
    input  logic      rst_i,
    tlb_lookup_if.tlb lookup,
    tlb_fill_if.tlb   fill,
    input  logic      update_i
);

    sv32_pkg::tlb_entry_t                entries_q [sv32_pkg::TLB_ENTRIES];
    sv32_pkg::tlb_entry_t                fill_entry;
    logic [sv32_pkg::TLB_ENTRIES-1:0]    match;
    logic [sv32_pkg::TLB_PTR_W-1:0]      rr_ptr_q;

    // Superpages compare VPN[1] only
    always_comb begin
        for (int k = 0; k < sv32_pkg::TLB_ENTRIES; k++) begin
            if (entries_q[k].page_4m) begin
                match[k] = entries_q[k].valid &
                           (entries_q[k].vpn[sv32_pkg::VPN_W-1:sv32_pkg::VPN_PART_W] ==
                            lookup.vpn[sv32_pkg::VPN_W-1:sv32_pkg::VPN_PART_W]);
            end else begin
                match[k] = entries_q[k].valid & (entries_q[k].vpn == lookup.vpn);
            end
        end
    end

    // At most one entry matches, since a page is only walked on a miss
    always_comb begin
        lookup.ppn     = '0;
        lookup.page_4m = 1'b0;
        for (int k = 0; k < sv32_pkg::TLB_ENTRIES; k++) begin
            if (match[k]) begin
                lookup.ppn     = entries_q[k].ppn;
                lookup.page_4m = entries_q[k].page_4m;
            end
        end
    end

    assign lookup.hit = lookup.req & (|match);

    // Entry built from the walker result
    always_comb begin
        fill_entry         = '0;
        fill_entry.valid   = 1'b1;
        fill_entry.vpn     = fill.vpn;
        fill_entry.ppn     = fill.pte.ppn;
        fill_entry.page_4m = fill.page_4m;
    end

    // Flush takes precedence over a refill in the same cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rr_ptr_q <= '0;
            for (int k = 0; k < sv32_pkg::TLB_ENTRIES; k++) begin
                entries_q[k].valid <= 1'b0;
            end
        end else if (lookup.flush) begin
            for (int k = 0; k < sv32_pkg::TLB_ENTRIES; k++) begin
                entries_q[k].valid <= 1'b0;
            end
        end else if (update_i) begin
            entries_q[rr_ptr_q] <= fill_entry;
            // Wraps around after the last entry
            rr_ptr_q            <= rr_ptr_q + 1'b1;
        end
    end

endmodule

/* hdl/ptw.sv */
`timescale 1ns/1ns

module ptw (
    input  logic                    clk,
    input  logic                    rst_i,
    input  sv32_pkg::ppn_t          satp_ppn_i,
    input  logic                    i_walk_i,
    input  logic                    d_walk_i,
    input  sv32_pkg::vaddr_t        i_vaddr_i,
    input  sv32_pkg::vaddr_t        d_vaddr_i,
    output logic                    pte_error_o,
    output mmu_ctrl_pkg::walk_src_e walk_src_o,
    tlb_fill_if.walker              fill,
    output logic                    mem_req_o,
    output sv32_pkg::paddr_t        mem_addr_o,
    input  sv32_pkg::pte_t          mem_rdata_i,
    input  logic                    mem_ack_i
);

    mmu_ctrl_pkg::ptw_state_e state_q;
    mmu_ctrl_pkg::walk_src_e  walk_src_q;
    sv32_pkg::vpn_t           walk_vpn_q;
    sv32_pkg::vpn_t           req_vpn;
    sv32_pkg::paddr_t         mem_addr_q;
    sv32_pkg::pte_t           pte_q;
    logic                     page_4m_q;
    logic                     pte_bad;
    logic                     pte_leaf;
    logic                     sp_misaligned;

    // Address of one PTE inside the table at base
    function automatic sv32_pkg::paddr_t pte_addr(
        input sv32_pkg::ppn_t                   base,
        input logic [sv32_pkg::VPN_PART_W-1:0] idx
    );
        sv32_pkg::paddr_t ofs;
        ofs = sv32_pkg::paddr_t'(idx) * sv32_pkg::PTE_BYTES;
        return {base, {sv32_pkg::PAGE_OFS_W{1'b0}}} + ofs;
    endfunction

    // Instruction side wins when both sides miss together
    assign req_vpn = i_walk_i ? i_vaddr_i[sv32_pkg::VA_W-1:sv32_pkg::PAGE_OFS_W]
                              : d_vaddr_i[sv32_pkg::VA_W-1:sv32_pkg::PAGE_OFS_W];

    // Decode of the PTE on the read data bus
    assign pte_bad       = ~mem_rdata_i.v | (mem_rdata_i.w & ~mem_rdata_i.r);
    assign pte_leaf      = mem_rdata_i.r | mem_rdata_i.x;
    assign sp_misaligned = |mem_rdata_i.ppn[sv32_pkg::VPN_PART_W-1:0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q    <= mmu_ctrl_pkg::PTW_IDLE;
            walk_src_q <= mmu_ctrl_pkg::WALK_INSTR;
        end else begin
            case (state_q)
                mmu_ctrl_pkg::PTW_IDLE: begin
                    if (i_walk_i | d_walk_i) begin
                        walk_src_q <= i_walk_i ? mmu_ctrl_pkg::WALK_INSTR
                                               : mmu_ctrl_pkg::WALK_DATA;
                        state_q    <= mmu_ctrl_pkg::PTW_L1_REQ;
                    end
                end
                mmu_ctrl_pkg::PTW_L1_REQ: begin
                    if (mem_ack_i) begin
                        if (pte_bad | (pte_leaf & sp_misaligned)) begin
                            state_q <= mmu_ctrl_pkg::PTW_ERROR;
                        end else if (pte_leaf) begin
                            state_q <= mmu_ctrl_pkg::PTW_FILL;
                        end else begin
                            state_q <= mmu_ctrl_pkg::PTW_L0_REQ;
                        end
                    end
                end
                mmu_ctrl_pkg::PTW_L0_REQ: begin
                    // No third level in Sv32
                    if (mem_ack_i) begin
                        if (pte_bad | ~pte_leaf) begin
                            state_q <= mmu_ctrl_pkg::PTW_ERROR;
                        end else begin
                            state_q <= mmu_ctrl_pkg::PTW_FILL;
                        end
                    end
                end
                // Fill and error each last a single cycle
                default: begin
                    state_q <= mmu_ctrl_pkg::PTW_IDLE;
                end
            endcase
        end
    end

    // Walk payload
    always_ff @(posedge clk) begin
        case (state_q)
            mmu_ctrl_pkg::PTW_IDLE: begin
                walk_vpn_q <= req_vpn;
                mem_addr_q <= pte_addr(satp_ppn_i,
                                       req_vpn[sv32_pkg::VPN_W-1:sv32_pkg::VPN_PART_W]);
            end
            mmu_ctrl_pkg::PTW_L1_REQ: begin
                if (mem_ack_i) begin
                    pte_q      <= mem_rdata_i;
                    page_4m_q  <= pte_leaf;
                    mem_addr_q <= pte_addr(mem_rdata_i.ppn,
                                           walk_vpn_q[sv32_pkg::VPN_PART_W-1:0]);
                end
            end
            mmu_ctrl_pkg::PTW_L0_REQ: begin
                if (mem_ack_i) begin
                    pte_q     <= mem_rdata_i;
                    page_4m_q <= 1'b0;
                end
            end
            default: begin
            end
        endcase
    end

    assign mem_req_o   = (state_q == mmu_ctrl_pkg::PTW_L1_REQ) |
                         (state_q == mmu_ctrl_pkg::PTW_L0_REQ);
    assign mem_addr_o  = mem_addr_q;
    assign pte_error_o = (state_q == mmu_ctrl_pkg::PTW_ERROR);
    assign walk_src_o  = walk_src_q;

    // Strobe goes only to the TLB of the side that walked
    assign fill.update_i = (state_q == mmu_ctrl_pkg::PTW_FILL) &
                           (walk_src_q == mmu_ctrl_pkg::WALK_INSTR);
    assign fill.update_d = (state_q == mmu_ctrl_pkg::PTW_FILL) &
                           (walk_src_q == mmu_ctrl_pkg::WALK_DATA);
    assign fill.vpn      = walk_vpn_q;
    assign fill.pte      = pte_q;
    assign fill.page_4m  = page_4m_q;

endmodule

/* hdl/mmu.sv */
`timescale 1ns/1ns

module mmu (
    input  logic             clk,
    input  logic             rst_i,

    // Translation control
    input  logic             en_vaddr_i,
    input  logic             en_ld_st_vaddr_i,
    input  logic             tlb_flush_i,
    input  sv32_pkg::ppn_t   satp_ppn_i,

    // Fetch side
    input  logic             i_req_i,
    input  sv32_pkg::vaddr_t i_vaddr_i,
    output sv32_pkg::paddr_t i_paddr_o,
    output logic             i_hit_o,
    output logic             i_page_fault_o,

    // Load/store side
    input  logic             d_req_i,
    input  logic             st_req_i,
    input  sv32_pkg::vaddr_t d_vaddr_i,
    output sv32_pkg::paddr_t d_paddr_o,
    output logic             d_hit_o,
    output logic             ld_page_fault_o,
    output logic             st_page_fault_o,

    // Page table read port
    output logic             mem_req_o,
    output sv32_pkg::paddr_t mem_addr_o,
    input  sv32_pkg::pte_t   mem_rdata_i,
    input  logic             mem_ack_i
);

    tlb_fill_if   fill_bus ();
    tlb_lookup_if ilookup ();
    tlb_lookup_if dlookup ();

    logic                    i_walk;
    logic                    d_walk;
    logic                    pte_error;
    mmu_ctrl_pkg::walk_src_e walk_src;

    // Page number and offset joined, VPN[0] kept for superpages
    function automatic sv32_pkg::paddr_t translate(
        input sv32_pkg::vaddr_t vaddr,
        input sv32_pkg::ppn_t   ppn,
        input logic             page_4m
    );
        sv32_pkg::paddr_t paddr;
        paddr = {ppn, vaddr[sv32_pkg::PAGE_OFS_W-1:0]};
        if (page_4m) begin
            paddr[21:12] = vaddr[21:12];
        end
        return paddr;
    endfunction

    assign ilookup.req   = i_req_i & en_vaddr_i;
    assign ilookup.vpn   = i_vaddr_i[sv32_pkg::VA_W-1:sv32_pkg::PAGE_OFS_W];
    assign ilookup.flush = tlb_flush_i;

    assign dlookup.req   = d_req_i & en_ld_st_vaddr_i;
    assign dlookup.vpn   = d_vaddr_i[sv32_pkg::VA_W-1:sv32_pkg::PAGE_OFS_W];
    assign dlookup.flush = tlb_flush_i;

    tlb itlb (
        .clk      (clk),
        .rst_i    (rst_i),
        .lookup   (ilookup),
        .fill     (fill_bus),
        .update_i (fill_bus.update_i)
    );

    tlb dtlb (
        .clk      (clk),
        .rst_i    (rst_i),
        .lookup   (dlookup),
        .fill     (fill_bus),
        .update_i (fill_bus.update_d)
    );

    // A miss on an enabled request starts a walk
    assign i_walk = ilookup.req & ~ilookup.hit;
    assign d_walk = dlookup.req & ~dlookup.hit;

    ptw i_ptw (
        .clk         (clk),
        .rst_i       (rst_i),
        .satp_ppn_i  (satp_ppn_i),
        .i_walk_i    (i_walk),
        .d_walk_i    (d_walk),
        .i_vaddr_i   (i_vaddr_i),
        .d_vaddr_i   (d_vaddr_i),
        .pte_error_o (pte_error),
        .walk_src_o  (walk_src),
        .fill        (fill_bus),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ack_i   (mem_ack_i)
    );

    // Bare mode passes the address through in the request cycle
    assign i_paddr_o = en_vaddr_i ? translate(i_vaddr_i, ilookup.ppn, ilookup.page_4m)
                                  : sv32_pkg::paddr_t'(i_vaddr_i);
    assign i_hit_o   = en_vaddr_i ? (ilookup.hit & ~tlb_flush_i) : i_req_i;

    assign d_paddr_o = en_ld_st_vaddr_i ? translate(d_vaddr_i, dlookup.ppn, dlookup.page_4m)
                                        : sv32_pkg::paddr_t'(d_vaddr_i);
    assign d_hit_o   = en_ld_st_vaddr_i ? dlookup.hit : d_req_i;

    // Walker errors become page faults of the side that walked
    always_comb begin
        i_page_fault_o  = 1'b0;
        ld_page_fault_o = 1'b0;
        st_page_fault_o = 1'b0;
        if (pte_error) begin
            if (walk_src == mmu_ctrl_pkg::WALK_INSTR) begin
                i_page_fault_o = 1'b1;
            end else if (st_req_i) begin
                st_page_fault_o = 1'b1;
            end else begin
                ld_page_fault_o = 1'b1;
            end
        end
    end

endmodule

/* tb/mmu_tb_model.svh */
`ifndef MMU_TB_MODEL_SVH
`define MMU_TB_MODEL_SVH

// Page table image, indexed by physical byte address of each PTE
sv32_pkg::pte_t pt_image [sv32_pkg::paddr_t];

function automatic sv32_pkg::pte_t img_read(input sv32_pkg::paddr_t addr);
    if (pt_image.exists(addr)) begin
        return pt_image[addr];
    end
    return '0;
endfunction

// Level 0 table with invalid, malformed and valid leaves
function automatic void fill_leaf_table(input sv32_pkg::ppn_t base);
    sv32_pkg::pte_t pte;
    logic [1:0]     kind;
    for (int idx = 0; idx < 16; idx++) begin
        pte     = '0;
        kind    = 2'(rand_bits(1'b0, 2));
        pte.ppn = 22'(rand_bits(1'b0, 22));
        pte.v   = (kind != 2'd0);
        pte.w   = 1'b1;
        pte.r   = (kind != 2'd1);
        pte.x   = 1'b1;
        pt_image[{base, 12'b0} + sv32_pkg::paddr_t'(idx * 4)] = pte;
    end
endfunction

// Region kind follows VPN[1] mod 4: table, superpage, invalid, misaligned
function automatic void build_image();
    sv32_pkg::pte_t   pte;
    sv32_pkg::paddr_t root;
    for (int r = 0; r < 8; r++) begin
        root = {SATP_PPN, 12'b0} + sv32_pkg::paddr_t'(r * 4);
        pte  = '0;
        case (r % 4)
            0: begin
                pte.v   = 1'b1;
                pte.ppn = L0_PPN_BASE + 22'(r);
                fill_leaf_table(pte.ppn);
            end
            1: begin
                pte.ppn = {12'(rand_bits(1'b0, 12)), 10'b0};
                pte.v   = 1'b1;
                pte.r   = 1'b1;
                pte.x   = 1'b1;
            end
            2: begin
                pte.ppn = 22'(rand_bits(1'b0, 22));
                pte.r   = 1'b1;
            end
            default: begin
                pte.ppn = {12'(rand_bits(1'b0, 12)), 9'(rand_bits(1'b0, 9)), 1'b1};
                pte.v   = 1'b1;
                pte.r   = 1'b1;
            end
        endcase
        pt_image[root] = pte;
    end
endfunction

// Reference Sv32 walk, returns 1 on a page fault
function automatic logic model_translate(input sv32_pkg::vaddr_t va,
                                         output sv32_pkg::paddr_t pa, output int reads);
    sv32_pkg::pte_t pte;
    pa    = '0;
    pte   = img_read({SATP_PPN, 12'b0} + sv32_pkg::paddr_t'(va[31:22]) * 4);
    reads = 1;
    if (!pte.v || (pte.w && !pte.r)) begin
        return 1'b1;
    end
    if (pte.r || pte.x) begin
        if (pte.ppn[9:0] != 10'd0) begin
            return 1'b1;
        end
        pa = {pte.ppn[21:10], va[21:0]};
        return 1'b0;
    end
    pte   = img_read({pte.ppn, 12'b0} + sv32_pkg::paddr_t'(va[21:12]) * 4);
    reads = 2;
    if (!pte.v || (pte.w && !pte.r) || !(pte.r || pte.x)) begin
        return 1'b1;
    end
    pa = {pte.ppn, va[11:0]};
    return 1'b0;
endfunction

`endif

/* tb/mmu_tb.sv */
`timescale 1ns/1ns

module mmu_tb;

    localparam int             NUM_TXN     = 70;
    localparam sv32_pkg::ppn_t SATP_PPN    = 22'h00100;
    localparam sv32_pkg::ppn_t L0_PPN_BASE = 22'h00200;

    logic clk, rst_i, en_vaddr_i, en_ld_st_vaddr_i, tlb_flush_i;
    logic i_req_i, i_hit_o, i_page_fault_o;
    logic d_req_i, st_req_i, d_hit_o, ld_page_fault_o, st_page_fault_o;
    logic mem_req_o, mem_ack_i;
    sv32_pkg::ppn_t   satp_ppn_i;
    sv32_pkg::vaddr_t i_vaddr_i, d_vaddr_i;
    sv32_pkg::paddr_t i_paddr_o, d_paddr_o, mem_addr_o;
    sv32_pkg::pte_t   mem_rdata_i;

    logic [15:0]      stim_lfsr = 16'd27879;
    logic [15:0]      resp_lfsr = 16'd27879;
    int               error_count = 0;
    int               check_count = 0;
    int               mem_count = 0;
    sv32_pkg::paddr_t read_addrs [$];

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [31:0] rand_bits(input logic resp, input int n);
        logic [31:0] v;
        logic [15:0] s;
        v = '0;
        s = resp ? resp_lfsr : stim_lfsr;
        for (int k = 0; k < n; k++) begin
            s = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
            v = {v[30:0], s[0]};
        end
        if (resp) resp_lfsr = s;
        else stim_lfsr = s;
        return v;
    endfunction

    `include "mmu_tb_model.svh"

    mmu i_mmu (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_paddr(input sv32_pkg::paddr_t got, input sv32_pkg::paddr_t exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_fault(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_mem_count(input int got, input int exp, input string what);
        check_count++;
        if (got != exp) begin
            error_count++;
            $display("** Error at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // Memory responder with 0 to 3 wait cycles
    initial begin
        logic       pending;
        logic [1:0] wait_cnt;
        pending     = 1'b0;
        wait_cnt    = '0;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(posedge clk);
            if (rst_i || mem_ack_i) begin
                mem_ack_i <= 1'b0;
            end else if (mem_req_o) begin
                if (!pending) begin
                    pending = 1'b1;
                    wait_cnt = 2'(rand_bits(1'b1, 2));
                    mem_count++;
                    read_addrs.push_back(mem_addr_o);
                end
                if (wait_cnt == 2'd0) begin
                    pending = 1'b0;
                    mem_ack_i   <= 1'b1;
                    mem_rdata_i <= img_read(mem_addr_o);
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    // Requester holds its request until a hit or a fault, then drops it
    task automatic access(input logic data_side, input logic store, input sv32_pkg::vaddr_t va);
        sv32_pkg::paddr_t exp_pa;
        int               reads;
        logic             exp_f;
        logic             bare;
        logic             done;
        int               waited;
        @(posedge clk);
        // Mode as seen by the DUT in the request cycle
        bare = data_side ? !en_ld_st_vaddr_i : !en_vaddr_i;
        exp_f = bare ? 1'b0 : model_translate(va, exp_pa, reads);
        if (bare) exp_pa = sv32_pkg::paddr_t'(va);
        if (data_side) begin
            d_req_i   <= 1'b1;
            st_req_i  <= store;
            d_vaddr_i <= va;
        end else begin
            i_req_i   <= 1'b1;
            i_vaddr_i <= va;
        end
        done = 1'b0;
        waited = 0;
        while (!done) begin
            @(negedge clk);
            waited++;
            done = data_side ? (d_hit_o | ld_page_fault_o | st_page_fault_o)
                             : (i_hit_o | i_page_fault_o);
        end
        check_fault(i_page_fault_o, exp_f & !data_side, "fetch fault");
        check_fault(ld_page_fault_o, exp_f & data_side & !store, "load fault");
        check_fault(st_page_fault_o, exp_f & data_side & store, "store fault");
        if (bare) check_fault(waited == 1, 1'b1, "bare hit in request cycle");
        if (!exp_f) begin
            check_paddr(data_side ? d_paddr_o : i_paddr_o, exp_pa, "physical address");
        end
        @(posedge clk);
        if (data_side) d_req_i <= 1'b0;
        else i_req_i <= 1'b0;
    endtask

    function automatic sv32_pkg::vaddr_t rand_vaddr();
        logic [9:0] vpn1;
        logic [9:0] vpn0;
        vpn1 = 10'(rand_bits(1'b0, 3));
        vpn0 = (vpn1[1:0] == 2'd0) ? 10'(rand_bits(1'b0, 4)) : 10'(rand_bits(1'b0, 10));
        return {vpn1, vpn0, 12'(rand_bits(1'b0, 12))};
    endfunction

    task automatic flush_tlbs();
        @(posedge clk);
        tlb_flush_i <= 1'b1;
        @(posedge clk);
        tlb_flush_i <= 1'b0;
    endtask

    initial begin
        repeat (NUM_TXN * 40 + 200) @(posedge clk);
        $display("Timeout: the DUT stopped answering requests");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        sv32_pkg::vaddr_t va;
        sv32_pkg::vaddr_t va2;
        sv32_pkg::paddr_t pa;
        int               reads;
        int               base;
        logic             side;
        rst_i = 1'b1;
        en_vaddr_i = 1'b0;
        en_ld_st_vaddr_i = 1'b0;
        tlb_flush_i = 1'b0;
        satp_ppn_i = SATP_PPN;
        i_req_i = 1'b0;
        i_vaddr_i = '0;
        d_req_i = 1'b0;
        st_req_i = 1'b0;
        d_vaddr_i = '0;
        build_image();
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;

        // Bare mode
        for (int n = 0; n < 4; n++) begin
            access(n[0], n[1], rand_bits(1'b0, 32));
        end
        check_mem_count(mem_count, 0, "reads in bare mode");
        @(posedge clk);
        en_vaddr_i <= 1'b1;
        en_ld_st_vaddr_i <= 1'b1;

        // Random translated accesses over all region kinds
        for (int n = 0; n < 40; n++) begin
            side = 1'(rand_bits(1'b0, 1));
            access(side, side & 1'(rand_bits(1'b0, 1)), rand_vaddr());
        end

        // Each fault kind from invalid and misaligned regions
        for (int n = 0; n < 6; n++) begin
            va = {10'(2 + n % 2), 22'(rand_bits(1'b0, 22))};
            access(n >= 2, n >= 4, va);
        end

        // Refill, hit without reads, then flush forces a new walk
        va = '0;
        for (int idx = 15; idx >= 0; idx--) begin
            if (!model_translate({10'd0, 10'(idx), 12'h5a4}, pa, reads)) begin
                va = {10'd0, 10'(idx), 12'h5a4};
            end
        end
        void'(model_translate(va, pa, reads));
        flush_tlbs();
        base = mem_count;
        access(1'b1, 1'b0, va);
        check_mem_count(mem_count - base, reads, "reads on miss");
        base = mem_count;
        access(1'b1, 1'b0, va);
        check_mem_count(mem_count - base, 0, "reads on hit");
        flush_tlbs();
        base = mem_count;
        access(1'b1, 1'b0, va);
        check_mem_count(mem_count - base, reads, "reads after flush");

        // Fetch and data misses together, fetch root PTE read first
        for (int n = 0; n < 8; n++) begin
            va = rand_vaddr();
            va2 = rand_vaddr();
            // Another root entry of the same region kind for the data side
            if (va2[31:22] == va[31:22]) begin
                va2[31:22] = va[31:22] ^ 10'd4;
            end
            flush_tlbs();
            read_addrs.delete();
            fork
                access(1'b0, 1'b0, va);
                access(1'b1, n[0], va2);
            join
            check_paddr(read_addrs[0], {SATP_PPN, 12'b0} + sv32_pkg::paddr_t'(va[31:22]) * 4,
                        "first walk read");
        end

        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sources.f */
hdl/sv32_pkg.sv
hdl/mmu_ctrl_pkg.sv
hdl/tlb_lookup_if.sv
hdl/tlb_fill_if.sv
hdl/tlb.sv
hdl/ptw.sv
hdl/mmu.sv
+incdir+tb
tb/mmu_tb.sv
